// ==== verilog/neuralNetPkg.sv ====
package neuralNetPkg;

	// Network sizes.
	localparam int inputCount = 10; // Fan-in of every neuron.
	localparam int hiddenCount = 10;
	localparam int classCount = 4;

	// Cycles from neuron input to neuron output.
	localparam int neuronLatency = 3;

	// Ten weights then the bias for each neuron.
	localparam int wordsPerNeuron = inputCount + 1;
	localparam int outputBase = hiddenCount * wordsPerNeuron; // First output neuron word.
	localparam int weightEntries = (hiddenCount + classCount) * wordsPerNeuron;

	// Single 8-bit words.
	typedef logic signed [7:0] activation;
	typedef logic signed [7:0] weight;

	// One full input vector for a neuron.
	typedef activation [inputCount-1:0] activationVector;

	// Everything a neuron needs besides its inputs.
	typedef struct packed
	{
		weight bias;
		weight [inputCount-1:0] w; // Lane k scales input k.
	} neuronWeights;

	// Configuration write port.
	typedef struct packed
	{
		logic strobe;
		logic [7:0] addr;
		weight data;
	} weightWrite;

	// Winning output class.
	typedef logic [1:0] classIndex;

endpackage

// ==== verilog/weightBank.sv ====
`timescale 1ns/1ps

module weightBank
	import neuralNetPkg::*;
(
	input logic clk,
	input logic reset,
	input weightWrite cfg,
	output neuronWeights [hiddenCount-1:0] hiddenWeights,
	output neuronWeights [classCount-1:0] outWeights
);

	weight bank [weightEntries];
	logic writeHit;

	// Addresses past the last neuron are dropped.
	assign writeHit = cfg.strobe && (cfg.addr < weightEntries);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < weightEntries; i++)
			begin
				bank[i] <= '0;
			end
		end
		else if (writeHit)
		begin
			bank[cfg.addr] <= cfg.data;
		end
	end

	// Hidden neurons own words 0 to outputBase-1.
	always_comb
	begin
		for (int n = 0; n < hiddenCount; n++)
		begin
			for (int k = 0; k < inputCount; k++)
			begin
				hiddenWeights[n].w[k] = bank[n * wordsPerNeuron + k];
			end
			hiddenWeights[n].bias = bank[n * wordsPerNeuron + inputCount]; // Last word.
		end
	end

	// Output neurons follow right after.
	always_comb
	begin
		for (int n = 0; n < classCount; n++)
		begin
			for (int k = 0; k < inputCount; k++)
			begin
				outWeights[n].w[k] = bank[outputBase + n * wordsPerNeuron + k];
			end
			outWeights[n].bias = bank[outputBase + n * wordsPerNeuron + inputCount];
		end
	end

endmodule

// ==== verilog/neuron.sv ====
`timescale 1ns/1ps

module neuron
	import neuralNetPkg::*;
(
	input logic clk,
	input logic reset,
	input activationVector inputs,
	input neuronWeights coeffs,
	output activation result
);

	activationVector inputsReg;
	activation products [inputCount];
	activation sumNext;
	activation sumReg;

	// Only the low byte of each product is kept.
	always_comb
	begin
		for (int k = 0; k < inputCount; k++)
		begin
			products[k] = activation'(inputsReg[k] * coeffs.w[k]);
		end
	end

	// Wraps at 8 bits without saturation.
	always_comb
	begin
		sumNext = coeffs.bias;
		for (int k = 0; k < inputCount; k++)
		begin
			sumNext = sumNext + products[k];
		end
	end

	// Stage 1 captures the inputs.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputsReg <= '0;
		end
		else
		begin
			inputsReg <= inputs;
		end
	end

	// Stage 2 holds the sum, stage 3 the ReLU.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			sumReg <= sumNext;
			result <= sumReg[7] ? activation'(0) : sumReg; // Negative clamps to zero.
		end
	end

endmodule

// ==== verilog/denseLayer.sv ====
`timescale 1ns/1ps

module denseLayer
	import neuralNetPkg::*;
#(
	parameter int neuronCount = hiddenCount
)
(
	input logic clk,
	input logic reset,
	input activationVector layerIn,
	input logic layerInValid,
	input neuronWeights [neuronCount-1:0] coeffs,
	output activation [neuronCount-1:0] layerOut,
	output logic layerOutValid
);

	// One bit per neuron stage.
	logic [neuronLatency-1:0] validPipe;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[neuronLatency-2:0], layerInValid};
		end
	end

	assign layerOutValid = validPipe[neuronLatency-1]; // Lines up with result.

	// All neurons see the same vector.
	for (genvar n = 0; n < neuronCount; n++)
	begin : neuronSlot
		neuron unit
		(
			.clk(clk),
			.reset(reset),
			.inputs(layerIn),
			.coeffs(coeffs[n]),
			.result(layerOut[n])
		);
	end

endmodule

// ==== verilog/maxSelect.sv ====
`timescale 1ns/1ps

module maxSelect
	import neuralNetPkg::*;
(
	input logic clk,
	input logic reset,
	input activation [classCount-1:0] scoresIn,
	input logic scoresInValid,
	output activation [classCount-1:0] scores,
	output classIndex classId,
	output logic outValid
);

	classIndex bestIndex;
	activation bestScore;

	// Strict greater-than keeps the lowest index on a tie.
	always_comb
	begin
		bestIndex = '0;
		bestScore = scoresIn[0];
		for (int c = 1; c < classCount; c++)
		begin
			if (scoresIn[c] > bestScore)
			begin
				bestIndex = classIndex'(c);
				bestScore = scoresIn[c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			scores <= '0;
			classId <= '0;
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= scoresInValid;
			if (scoresInValid)
			begin
				scores <= scoresIn; // Held until the next vector.
				classId <= bestIndex;
			end
		end
	end

endmodule

// ==== verilog/classifierTop.sv ====
`timescale 1ns/1ps

module classifierTop
	import neuralNetPkg::*;
(
	input logic clk,
	input logic reset,
	input weightWrite cfg,
	input activationVector inVector,
	input logic inValid,
	output activation [classCount-1:0] scores,
	output classIndex classId,
	output logic outValid
);

	neuronWeights [hiddenCount-1:0] hiddenWeights;
	neuronWeights [classCount-1:0] outWeights;
	activation [hiddenCount-1:0] hiddenOut; // Doubles as the next fan-in.
	logic hiddenValid;
	activation [classCount-1:0] layerScores;
	logic scoresValid;

	weightBank weights
	(
		.clk(clk),
		.reset(reset),
		.cfg(cfg),
		.hiddenWeights(hiddenWeights),
		.outWeights(outWeights)
	);

	denseLayer #(.neuronCount(hiddenCount)) hiddenLayer
	(
		.clk(clk),
		.reset(reset),
		.layerIn(inVector),
		.layerInValid(inValid),
		.coeffs(hiddenWeights),
		.layerOut(hiddenOut),
		.layerOutValid(hiddenValid)
	);

	denseLayer #(.neuronCount(classCount)) outputLayer
	(
		.clk(clk),
		.reset(reset),
		.layerIn(hiddenOut),
		.layerInValid(hiddenValid),
		.coeffs(outWeights),
		.layerOut(layerScores),
		.layerOutValid(scoresValid)
	);

	// Last stage of the 7-cycle pipeline.
	maxSelect argmax
	(
		.clk(clk),
		.reset(reset),
		.scoresIn(layerScores),
		.scoresInValid(scoresValid),
		.scores(scores),
		.classId(classId),
		.outValid(outValid)
	);

endmodule

// ==== verification/clockGen.sv ====
`timescale 1ns/1ps

module clockGen
#(
	parameter int periodNs = 40,
	parameter int resetCycles = 4
)
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(periodNs / 2);
			clk = ~clk;
		end
	end

	initial
	begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0; // Released on a falling edge.
	end

endmodule

// ==== verification/classifierTb.sv ====
`timescale 1ns/1ps

module classifierTb
	import neuralNetPkg::*;
();

	localparam int clockPeriod = 40;
	localparam int resetCycles = 4;
	localparam int pipelineLatency = 7;
	localparam int timeoutMargin = 20;
	localparam string stimPath = "verification/classifierStim.txt";

	// One line of the stim file.
	typedef struct packed
	{
		logic isVector;
		logic [7:0] addr;
		weight data;
		activationVector vec;
		activation [classCount-1:0] expScores;
		classIndex expClass;
	} stimRecord;

	// What one vector should produce.
	typedef struct packed
	{
		activation [classCount-1:0] scores;
		classIndex classId;
		logic [31:0] issueCycle;
		logic [31:0] vectorNum;
	} expectation;

	logic clk;
	logic reset;
	weightWrite cfg;
	activationVector inVector;
	logic inValid;
	activation [classCount-1:0] scores;
	classIndex classId;
	logic outValid;

	stimRecord records[$];
	expectation expectQ[$];
	int cycleNum = 0; // Falling edges since reset release.
	int vectorCount = 0;
	int resultsSeen = 0;
	int timeoutCount = 0;
	int cycleLimit = 0;

	clockGen #(.periodNs(clockPeriod), .resetCycles(resetCycles)) clocks
	(
		.clk(clk),
		.reset(reset)
	);

	classifierTop DUT
	(
		.clk(clk),
		.reset(reset),
		.cfg(cfg),
		.inVector(inVector),
		.inValid(inValid),
		.scores(scores),
		.classId(classId),
		.outValid(outValid)
	);

	task automatic checkValue(input string testName, input logic signed [31:0] expected,
		input logic signed [31:0] actual);
		if (expected !== actual)
		begin
			$display("FAIL %s expected %0d actual %0d", testName, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Value mismatch in %s", testName);
		end
	endtask

	task automatic readStim();
		int fd;
		int count;
		int wantCount;
		int fields[15];
		string line;
		string body;
		stimRecord rec;
		fd = $fopen(stimPath, "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file %s", stimPath);
			$display("Simulation failed");
			$fatal(1, "Missing stimulus file");
		end
		while (!$feof(fd))
		begin
			line = "";
			count = $fgets(line, fd);
			if (count > 1 && (line.getc(0) == "W" || line.getc(0) == "V"))
			begin
				rec = '0;
				body = line.substr(1, line.len() - 1);
				if (line.getc(0) == "W")
				begin
					count = $sscanf(body, "%d %d", fields[0], fields[1]);
					rec.addr = 8'(fields[0]);
					rec.data = weight'(fields[1]);
					wantCount = 2;
				end
				else
				begin
					count = $sscanf(body, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
						fields[0], fields[1], fields[2], fields[3], fields[4],
						fields[5], fields[6], fields[7], fields[8], fields[9],
						fields[10], fields[11], fields[12], fields[13], fields[14]);
					rec.isVector = 1'b1;
					for (int k = 0; k < inputCount; k++)
					begin
						rec.vec[k] = activation'(fields[k]);
					end
					for (int c = 0; c < classCount; c++)
					begin
						rec.expScores[c] = activation'(fields[inputCount + c]);
					end
					rec.expClass = classIndex'(fields[14]);
					wantCount = 15;
				end
				if (count != wantCount)
				begin
					$display("Malformed line in the stimulus file: %s", line);
					$display("Simulation failed");
					$fatal(1, "Bad stimulus line");
				end
				records.push_back(rec);
			end
		end
		$fclose(fd);
	endtask

	task automatic sampleOutputs();
		expectation exp;
		string tag;
		if (outValid === 1'b1)
		begin
			if (expectQ.size() == 0)
			begin
				$display("outValid went high at cycle %0d with no vector in flight", cycleNum);
				$display("Simulation failed");
				$fatal(1, "Unexpected result");
			end
			else
			begin
				exp = expectQ.pop_front();
				tag = $sformatf("vector %0d", exp.vectorNum);
				checkValue({tag, " latency"}, pipelineLatency, cycleNum - int'(exp.issueCycle));
				for (int c = 0; c < classCount; c++)
				begin
					checkValue($sformatf("%s score%0d", tag, c), 32'(exp.scores[c]),
						32'(scores[c]));
				end
				checkValue({tag, " class"}, 32'(exp.classId), 32'(classId));
				resultsSeen++;
			end
		end
		else if (resultsSeen == 0)
		begin
			// Nothing has come out yet, so the ports still show reset values.
			checkValue("idle outValid", 0, 32'(outValid));
			for (int c = 0; c < classCount; c++)
			begin
				checkValue($sformatf("idle score%0d", c), 0, 32'(scores[c]));
			end
			checkValue("idle class", 0, 32'(classId));
		end
	endtask

	task automatic stepCycle();
		@(negedge clk);
		cycleNum++;
		sampleOutputs();
	endtask

	task automatic applyRecord(input stimRecord rec);
		expectation exp;
		if (rec.isVector)
		begin
			cfg = '0;
			inVector = rec.vec;
			inValid = 1'b1;
			exp.scores = rec.expScores;
			exp.classId = rec.expClass;
			exp.issueCycle = 32'(cycleNum);
			exp.vectorNum = 32'(vectorCount);
			expectQ.push_back(exp);
			vectorCount++;
		end
		else
		begin
			cfg.strobe = 1'b1;
			cfg.addr = rec.addr;
			cfg.data = rec.data;
			inVector = '0;
			inValid = 1'b0;
		end
	endtask

	always @(posedge clk)
	begin
		timeoutCount++;
		if (timeoutCount >= cycleLimit)
		begin
			$display("Run did not finish within %0d cycles", cycleLimit);
			$display("Simulation failed");
			$fatal(1, "Timeout");
		end
	end

	initial
	begin
		cfg = '0;
		inVector = '0;
		inValid = 1'b0;
		readStim();
		cycleLimit = resetCycles + records.size() + pipelineLatency + timeoutMargin;
		@(negedge reset);
		foreach (records[i])
		begin
			stepCycle();
			applyRecord(records[i]);
		end
		stepCycle();
		cfg = '0;
		inVector = '0;
		inValid = 1'b0;
		repeat (pipelineLatency + 1) stepCycle(); // Drain with one spare cycle.
		if (expectQ.size() != 0)
		begin
			$display("%0d vectors never produced a result", expectQ.size());
			$display("Simulation failed");
			$fatal(1, "Results missing");
		end
		else
		begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

// ==== verification/classifierStim.txt ====
# W addr data : write signed decimal data to weight bank address addr.
# V x0 .. x9 s0 s1 s2 s3 class : input vector, expected scores and winning class.
#
# Hidden neuron 0 passes x0, hidden neuron 1 passes x1.
W 0 1
W 12 1
# Hidden neuron 2 is 16*x2 + x3, so large products keep only their low byte.
W 24 16
W 25 1
# Hidden neuron 3 is 5 - x4, bias in the last word.
W 37 -1
W 43 5
# Output 0 = h0.
W 110 1
# Output 1 = h1 + h3.
W 122 1
W 124 1
# Output 2 = h2.
W 134 1
# Output 3 = h1 - h0 + 1, bias at the last valid address.
W 143 -1
W 144 1
W 153 1
# Out of range, dropped by the weight bank.
W 154 7
W 164 50
#
# Small values through both layers.
V 3 5 2 1 1 0 0 0 0 0 3 9 33 3 2
# Hidden 3 and output 3 go negative and clamp to zero.
V 10 4 0 0 9 0 0 0 0 0 10 4 0 0 0
# 16*20 = 320 keeps 64.
V 1 2 20 3 0 0 0 0 0 0 1 7 67 2 2
# Hidden 2 sums to 132, which wraps negative.
V 6 6 7 20 2 0 0 0 0 0 6 9 0 1 1
# Output 1 sums to 155 and clamps.
V 40 50 -1 20 -100 0 0 0 0 0 40 0 4 11 0
# Tie between classes 0 and 2.
V 33 0 2 1 5 0 0 0 0 9 33 0 33 0 0
# Tie between classes 1 and 2.
V 0 10 0 15 0 0 0 0 0 0 0 15 15 11 1
# Tie between classes 2 and 3, negative x0 clamps h0.
V -5 20 1 5 5 0 0 0 0 0 0 20 21 21 2
# Inputs 5 to 9 carry zero weights.
V 0 0 0 0 5 11 -22 33 -44 55 0 0 0 1 3

// ==== classifier.f ====
verilog/neuralNetPkg.sv
verilog/weightBank.sv
verilog/neuron.sv
verilog/denseLayer.sv
verilog/maxSelect.sv
verilog/classifierTop.sv
verification/clockGen.sv
verification/classifierTb.sv

// ==== Makefile ====
SIM ?= verilator
FLAGS ?= --binary --timing
TOP ?= classifierTb
FILELIST ?= classifier.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
